// File: md_pkg.sv
package md_pkg;

   // register width of the core
   localparam int xlen = 32;

   typedef logic [xlen-1:0]   xlen_t;   // one register value
   typedef logic [2*xlen-1:0] dxlen_t;  // accumulator, shifted divisor
   typedef logic [4:0]        count_t;  // step counter, 31 down to 0
   typedef logic [2:0]        funct3_t;
   typedef logic [1:0]        out_sel_t;

   // RV32M funct3, OP opcode with funct7 = 0000001
   localparam funct3_t F3_MUL    = 3'b000;
   localparam funct3_t F3_MULH   = 3'b001;
   localparam funct3_t F3_MULHSU = 3'b010;
   localparam funct3_t F3_MULHU  = 3'b011;
   localparam funct3_t F3_DIV    = 3'b100;
   localparam funct3_t F3_DIVU   = 3'b101;
   localparam funct3_t F3_REM    = 3'b110;
   localparam funct3_t F3_REMU   = 3'b111;

   // which word of the corrected value goes out
   localparam out_sel_t OUT_LO  = 2'd0;  // low product word or quotient
   localparam out_sel_t OUT_HI  = 2'd1;  // high product word
   localparam out_sel_t OUT_REM = 2'd2;  // remainder
   // 2'd3 unused

endpackage

// File: md_if.sv
`timescale 1ns/1ns

// decode to execute
interface md_cmd_if;
   import md_pkg::*;

   logic     start;    // request accepted this cycle
   logic     ready;    // execute idle
   logic     is_div;
   xlen_t    mag_1;    // dividend or multiplicand magnitude
   xlen_t    mag_2;    // divisor or multiplier magnitude
   logic     negate;   // final value gets negated
   out_sel_t out_sel;

   modport dec (
      output start, is_div, mag_1, mag_2, negate, out_sel,
      input  ready
   );

   modport exe (
      input  start, is_div, mag_1, mag_2, negate, out_sel,
      output ready
   );

endinterface

// execute to result
interface md_raw_if;
   import md_pkg::*;

   logic     done;     // one cycle, no back-pressure
   dxlen_t   acc;      // product or quotient magnitude
   xlen_t    rem;      // remainder magnitude
   logic     negate;
   out_sel_t out_sel;

   modport exe (
      output done, acc, rem, negate, out_sel
   );

   modport res (
      input  done, acc, rem, negate, out_sel
   );

endinterface

// File: md_decode.sv
`timescale 1ns/1ns

module md_decode (
   md_cmd_if.dec           cmd,
   input  logic            req_valid,
   input  md_pkg::funct3_t req_funct3,
   input  md_pkg::xlen_t   req_rs1,
   input  md_pkg::xlen_t   req_rs2
);
   import md_pkg::*;

   logic signed_1;
   logic signed_2;
   logic sign_1;
   logic sign_2;
   logic is_rem;
   logic div_by_zero;

   always_comb begin
      signed_1 = 1'b0;
      signed_2 = 1'b0;
      is_rem   = 1'b0;
      case (req_funct3)
         F3_MULH: begin
            signed_1    = 1'b1;
            signed_2    = 1'b1;
            cmd.out_sel = OUT_HI;
         end
         F3_MULHSU: begin
            signed_1    = 1'b1;  // rs2 stays unsigned
            cmd.out_sel = OUT_HI;
         end
         F3_MULHU: cmd.out_sel = OUT_HI;
         F3_DIV: begin
            signed_1    = 1'b1;
            signed_2    = 1'b1;
            cmd.out_sel = OUT_LO;
         end
         F3_DIVU: cmd.out_sel = OUT_LO;
         F3_REM: begin
            signed_1    = 1'b1;
            signed_2    = 1'b1;
            is_rem      = 1'b1;
            cmd.out_sel = OUT_REM;
         end
         F3_REMU: begin
            is_rem      = 1'b1;
            cmd.out_sel = OUT_REM;
         end
         default: cmd.out_sel = OUT_LO;  // MUL low word is sign-agnostic
      endcase
   end

   assign sign_1 = signed_1 & req_rs1[xlen-1];
   assign sign_2 = signed_2 & req_rs2[xlen-1];

   // most negative value maps onto itself and is still the right unsigned magnitude
   assign cmd.mag_1 = sign_1 ? xlen_t'(-req_rs1) : req_rs1;
   assign cmd.mag_2 = sign_2 ? xlen_t'(-req_rs2) : req_rs2;

   assign cmd.is_div  = req_funct3[2];
   assign div_by_zero = (req_rs2 == '0);

   // zero divisor leaves the all-ones quotient as -1
   assign cmd.negate = is_rem ? sign_1
                              : (sign_1 ^ sign_2) & ~(cmd.is_div & div_by_zero);

   assign cmd.start = req_valid & cmd.ready;

   // funct3[2] and the output selection have to agree
   always_comb begin
      if (cmd.start) begin
         assert (cmd.is_div ? (cmd.out_sel inside {OUT_LO, OUT_REM})
                            : (cmd.out_sel inside {OUT_LO, OUT_HI}))
            else $error("md_decode: out_sel does not fit the operation");
      end
   end

endmodule

// File: md_execute.sv
`timescale 1ns/1ns

module md_execute (
   input  logic  clk,
   input  logic  reset,
   md_cmd_if.exe cmd,
   md_raw_if.exe raw
);
   import md_pkg::*;

   typedef enum logic [1:0] {
      s_idle,
      s_compute,
      s_done
   } state_t;

   state_t   state;
   dxlen_t   a;        // multiplicand, or running remainder
   dxlen_t   b;        // shifted multiplier or divisor
   dxlen_t   acc;      // product or quotient bits
   count_t   counter;
   logic     is_div;
   logic     negate;
   out_sel_t out_sel;
   logic     a_geq;

   assign cmd.ready = (state == s_idle);
   assign a_geq     = (a >= b);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= s_idle;
      end else begin
         case (state)
            s_idle: begin
               if (cmd.start) begin
                  state <= s_compute;
               end
            end
            s_compute: begin
               if (counter == '0) begin
                  state <= s_done;  // last step
               end
            end
            s_done:  state <= s_idle;
            default: state <= s_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (cmd.start) begin
         a       <= {{xlen{1'b0}}, cmd.mag_1};
         b       <= {1'b0, cmd.mag_2, {(xlen-1){1'b0}}};  // mag_2 << 31
         acc     <= '0;
         counter <= count_t'(xlen - 1);
         is_div  <= cmd.is_div;
         negate  <= cmd.negate;
         out_sel <= cmd.out_sel;
      end else if (state == s_compute) begin
         counter <= counter - 1'b1;
         b       <= b >> 1;
         if (is_div) begin
            // restoring step, zero divisor sets every bit
            if (a_geq) begin
               a            <= a - b;
               acc[counter] <= 1'b1;
            end
         end else if (a[counter]) begin
            acc <= acc + b;  // b is mag_2 << counter here
         end
      end
   end

   assign raw.done    = (state == s_done);
   assign raw.acc     = acc;
   assign raw.rem     = a[xlen-1:0];
   assign raw.negate  = negate;
   assign raw.out_sel = out_sel;

   // done only right after the final step
   done_after_last_step: assert property (
      @(posedge clk) disable iff (reset)
      raw.done |-> $past(state == s_compute && counter == '0)
   ) else $error("md_execute: done without a completed step sequence");

   // decode must hold start off while busy
   start_only_when_idle: assert property (
      @(posedge clk) disable iff (reset)
      cmd.start |-> state == s_idle
   ) else $error("md_execute: start while not idle");

endmodule

// File: md_result.sv
`timescale 1ns/1ns

module md_result (
   input  logic          clk,
   input  logic          reset,
   md_raw_if.res         raw,
   output logic          resp_valid,
   output md_pkg::xlen_t resp_result
);
   import md_pkg::*;

   dxlen_t chosen;
   dxlen_t corrected;
   xlen_t  word;

   always_comb begin
      if (raw.out_sel == OUT_REM) begin
         chosen = {{xlen{1'b0}}, raw.rem};
      end else begin
         chosen = raw.acc;
      end
   end

   // two's complement over the full 64 bits so MULH sees the borrow
   assign corrected = raw.negate ? dxlen_t'(-chosen) : chosen;

   always_comb begin
      if (raw.out_sel == OUT_HI) begin
         word = corrected[2*xlen-1:xlen];
      end else begin
         word = corrected[xlen-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= raw.done;
      end
   end

   always_ff @(posedge clk) begin
      if (raw.done) begin
         resp_result <= word;  // held until the next done
      end
   end

   // each operation yields a single response strobe
   single_cycle_resp: assert property (
      @(posedge clk) disable iff (reset)
      resp_valid |=> !resp_valid
   ) else $error("md_result: resp_valid high on consecutive cycles");

endmodule

// File: mul_div_unit.sv
`timescale 1ns/1ns

module mul_div_unit (
   input  logic            clk,
   input  logic            reset,
   input  logic            req_valid,
   input  md_pkg::funct3_t req_funct3,
   input  md_pkg::xlen_t   req_rs1,
   input  md_pkg::xlen_t   req_rs2,
   output logic            req_ready,
   output logic            resp_valid,
   output md_pkg::xlen_t   resp_result
);

   md_cmd_if cmd_if ();
   md_raw_if raw_if ();

   assign req_ready = cmd_if.ready;

   // funct3 and operands to magnitude command
   md_decode u_decode (
      .cmd        (cmd_if.dec),
      .req_valid  (req_valid),
      .req_funct3 (req_funct3),
      .req_rs1    (req_rs1),
      .req_rs2    (req_rs2)
   );

   md_execute u_execute (
      .clk   (clk),
      .reset (reset),
      .cmd   (cmd_if.exe),
      .raw   (raw_if.exe)
   );

   // sign fix-up and output register
   md_result u_result (
      .clk         (clk),
      .reset       (reset),
      .raw         (raw_if.res),
      .resp_valid  (resp_valid),
      .resp_result (resp_result)
   );

endmodule

// File: tb_mul_div.sv
`timescale 1ns/1ns

module tb_mul_div;
   import md_pkg::*;

   localparam int n_random   = 400;
   localparam int n_directed = 8;
   localparam int latency    = 34;  // acceptance edge to resp_valid edge
   localparam int period     = 20;
   localparam int timeout_ns = (n_random + n_directed) * 40 * period + 200 * period;

   typedef struct packed {
      funct3_t     f3;
      xlen_t       rs1;
      xlen_t       rs2;
      xlen_t       expected;
      logic [31:0] cycle;
   } pending_t;

   logic    clk;
   logic    reset;
   logic    req_valid;
   funct3_t req_funct3;
   xlen_t   req_rs1;
   xlen_t   req_rs2;
   logic    req_ready;
   logic    resp_valid;
   xlen_t   resp_result;

   logic [31:0] rng_state = 32'h64fc;
   logic [31:0] cycle = '0;
   int          errors = 0;
   int          accepted = 0;
   int          responses = 0;
   pending_t    pending[$];   // accepted requests with the oldest first
   pending_t    entry;
   pending_t    head;

   mul_div_unit UUT (
      .clk         (clk),
      .reset       (reset),
      .req_valid   (req_valid),
      .req_funct3  (req_funct3),
      .req_rs1     (req_rs1),
      .req_rs2     (req_rs2),
      .req_ready   (req_ready),
      .resp_valid  (resp_valid),
      .resp_result (resp_result)
   );

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   function logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // one in three from the corner set
   function xlen_t pick_operand();
      logic [31:0] r;
      logic [31:0] pick;
      r = next_rand();
      if ((r >> 16) % 3 != 0) begin
         return next_rand();
      end
      pick = (next_rand() >> 16) % 5;
      case (pick)
         0:       return 32'h0000_0000;
         1:       return 32'h0000_0001;
         2:       return 32'hffff_ffff;
         3:       return 32'h8000_0000;
         default: return 32'h7fff_ffff;
      endcase
   endfunction

   // reference model for the RV32M rules on 64-bit arithmetic
   function xlen_t model_result(funct3_t f3, xlen_t rs1, xlen_t rs2);
      logic signed [63:0] s1;
      logic signed [63:0] s2;
      logic [63:0]        u1;
      logic [63:0]        u2;
      logic [63:0]        prod;
      logic               overflow;
      s1       = {{32{rs1[31]}}, rs1};
      s2       = {{32{rs2[31]}}, rs2};
      u1       = {32'h0, rs1};
      u2       = {32'h0, rs2};
      overflow = (rs1 == 32'h8000_0000) && (rs2 == 32'hffff_ffff);
      prod     = '0;
      case (f3)
         F3_MUL, F3_MULH: prod = $unsigned(s1 * s2);
         F3_MULHSU:       prod = $unsigned(s1) * u2;  // rs2 zero-extended
         F3_MULHU:        prod = u1 * u2;
         default:         prod = '0;
      endcase
      case (f3)
         F3_MUL:                       return prod[31:0];
         F3_MULH, F3_MULHSU, F3_MULHU: return prod[63:32];
         F3_DIV: begin
            if (rs2 == '0) return '1;
            if (overflow) return 32'h8000_0000;
            return xlen_t'(s1 / s2);
         end
         F3_DIVU: begin
            if (rs2 == '0) return '1;
            return xlen_t'(u1 / u2);
         end
         F3_REM: begin
            if (rs2 == '0) return rs1;
            if (overflow) return '0;
            return xlen_t'(s1 % s2);  // sign follows the dividend
         end
         default: begin
            if (rs2 == '0) return rs1;
            return xlen_t'(u1 % u2);
         end
      endcase
   endfunction

   task automatic check_result(input string name, input xlen_t got, input xlen_t expected);
      if (got !== expected) begin
         errors++;
         $display("FAILED %s: got %h, expected %h", name, got, expected);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic expected);
      if (got !== expected) begin
         errors++;
         $display("FAILED %s: got %h, expected %h", name, got, expected);
      end
   endtask

   // holds req_valid until the accepting edge
   task automatic send_request(input funct3_t f3, input xlen_t rs1, input xlen_t rs2);
      req_valid  <= 1'b1;
      req_funct3 <= f3;
      req_rs1    <= rs1;
      req_rs2    <= rs2;
      do
         @(posedge clk);
      while (!req_ready);
      req_valid <= 1'b0;
   endtask

   // pre-edge values so a response is handled before a same-edge acceptance
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (!reset) begin
         if (resp_valid) begin
            responses++;
            if (pending.size() == 0) begin
               errors++;
               $display("response at cycle %0d with no request outstanding", cycle);
            end else begin
               head = pending.pop_front();
               if (int'(cycle - head.cycle) != latency) begin
                  errors++;
                  $display("response came %0d cycles after acceptance instead of %0d",
                           int'(cycle - head.cycle), latency);
               end
               check_result($sformatf("resp_result (funct3 %0d, rs1 %h, rs2 %h)",
                                      head.f3, head.rs1, head.rs2),
                            resp_result, head.expected);
               check_flag("req_ready", req_ready, 1'b1);
            end
         end
         if (req_valid && req_ready) begin
            entry.f3       = req_funct3;
            entry.rs1      = req_rs1;
            entry.rs2      = req_rs2;
            entry.expected = model_result(req_funct3, req_rs1, req_rs2);
            entry.cycle    = cycle;
            pending.push_back(entry);
            accepted++;
         end
      end
   end

   initial begin
      funct3_t f3;
      xlen_t   a;
      xlen_t   b;
      int      gap;
      req_valid  <= 1'b0;
      req_funct3 <= F3_MUL;
      req_rs1    <= '0;
      req_rs2    <= '0;
      reset      <= 1'b1;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_flag("req_ready", req_ready, 1'b1);
      check_flag("resp_valid", resp_valid, 1'b0);
      @(posedge clk);

      // zero divisor and overflow rules
      send_request(F3_DIV, 32'h1234_5678, 32'h0);
      send_request(F3_DIVU, 32'h8765_4321, 32'h0);
      send_request(F3_REM, 32'hfedc_ba98, 32'h0);
      send_request(F3_REMU, 32'h0bad_f00d, 32'h0);
      send_request(F3_DIV, 32'h8000_0000, 32'hffff_ffff);
      send_request(F3_REM, 32'h8000_0000, 32'hffff_ffff);
      send_request(F3_MULH, 32'h8000_0000, 32'h8000_0000);
      send_request(F3_MULHSU, 32'hffff_ffff, 32'hffff_ffff);

      for (int i = 0; i < n_random; i++) begin
         gap = (next_rand() >> 16) % 4;
         if ((next_rand() >> 16) % 16 == 0) begin
            gap = gap + 40;  // let the unit go idle now and then
         end
         repeat (gap) @(posedge clk);
         f3 = funct3_t'(next_rand() >> 29);
         a  = pick_operand();
         b  = pick_operand();
         send_request(f3, a, b);
      end

      while (pending.size() != 0) @(negedge clk);
      repeat (4) @(posedge clk);
      if (responses != accepted) begin
         errors++;
         $display("%0d responses for %0d accepted requests", responses, accepted);
      end
      $display("%0d errors, %0d requests accepted, %0d responses", errors, accepted, responses);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   initial begin
      #(timeout_ns);
      $display("timeout after %0d ns, %0d of %0d responses seen",
               timeout_ns, responses, n_random + n_directed);
      $display("Finished with errors");
      $finish;
   end

endmodule

// File: src.f
md_pkg.sv
md_if.sv
md_decode.sv
md_execute.sv
md_result.sv
mul_div_unit.sv
tb_mul_div.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -sv -f src.f --top-module tb_mul_div -Mdir obj_dir -o tb_mul_div
	@out="$$(./obj_dir/tb_mul_div)"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
